// File: testbench/eeprom_stim.txt
# op dev page addr data acks rdata, all hex except acks in binary
# W write, R read, A stop after address; acks are ctrl, addr, data or read ctrl
R a 0 00 00 111 00
W a 0 10 5a 111 00
R a 0 10 00 111 5a
W a 3 10 c3 111 00
R a 0 10 00 111 5a
R a 3 10 00 111 c3
W b 0 10 ff 000 00
R a 0 10 00 111 5a
R 5 0 10 00 000 ff
W a 7 ff 81 111 00
R a 7 ff 00 111 81
A a 7 ff 00 110 00
R a 7 ff 00 111 81
W a 7 ff 3c 111 00
R a 7 ff 00 111 3c
W a 0 10 a5 111 00
R a 0 10 00 111 a5
R a 3 10 00 111 c3
W a 5 00 01 111 00
W a 5 01 02 111 00
R a 5 00 00 111 01
R a 5 01 00 111 02
A a 2 20 00 110 00
R a 2 20 00 111 00
W 2 2 20 77 000 00
R a 2 20 00 111 00

// File: build.f
source/eeprom_pkg.sv
source/bus_sampler.sv
source/byte_shifter.sv
source/eeprom_ctrl.sv
source/eeprom_array.sv
source/eeprom_top.sv
testbench/tb_eeprom.sv

// File: Bender.yml
package:
  name: eeprom

sources:
  - source/eeprom_pkg.sv
  - source/bus_sampler.sv
  - source/byte_shifter.sv
  - source/eeprom_ctrl.sv
  - source/eeprom_array.sv
  - source/eeprom_top.sv
  - target: test
    files:
      - testbench/tb_eeprom.sv

// File: testbench/tb_eeprom.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom;

    localparam int         HALF       = 8;
    localparam int         N_RAND     = 12;
    localparam int         TXN_CYCLES = 800;
    localparam logic [3:0] DEV        = 4'b1010;

    typedef struct packed {
        logic [7:0] op;
        logic [3:0] dev;
        logic [2:0] page;
        logic [7:0] addr;
        logic [7:0] data;
        logic [2:0] acks;
        logic [7:0] rdata;
    } stim_t;

    logic        scl = 1'b0;
    logic        rst = 1'b1;
    logic        bus_clk = 1'b1;
    logic        sda_m = 1'b1;
    logic        sda_pull_low;
    wire         sda_line;
    stim_t       stim_q[$];
    logic [7:0]  shadow [0:2047];
    logic [31:0] lfsr = 32'hca63ad47;
    int          errors = 0;
    int          checks = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000;

    // Open-drain line, low if either side pulls
    assign sda_line = sda_m && !sda_pull_low;

    eeprom_top #(
        .SYNC_STAGES (2),
        .DEVICE_CODE (DEV)
    ) u_eeprom_top (
        .scl          (scl),
        .rst          (rst),
        .bus_clk      (bus_clk),
        .sda_in       (sda_line),
        .sda_pull_low (sda_pull_low)
    );

    always #50 scl = ~scl;

    always @(posedge scl)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("Timeout: the bus master did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;
        else
            return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            val  = {val[6:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] t=%0t %s: got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge scl);
    endtask

    // Entered with the bus idle or with the clock low after a ninth bit
    task automatic send_start;
        sda_m = 1'b1;
        wait_cycles(HALF / 2);
        bus_clk = 1'b1;
        wait_cycles(HALF);
        sda_m = 1'b0;
        wait_cycles(HALF);
        bus_clk = 1'b0;
        wait_cycles(HALF / 2);
    endtask

    task automatic send_stop;
        sda_m = 1'b0;
        wait_cycles(HALF / 2);
        bus_clk = 1'b1;
        wait_cycles(HALF);
        sda_m = 1'b1;
        wait_cycles(HALF);
    endtask

    task automatic send_bit(input logic b);
        sda_m = b;
        wait_cycles(HALF / 2);
        bus_clk = 1'b1;
        wait_cycles(HALF);
        bus_clk = 1'b0;
        wait_cycles(HALF / 2);
    endtask

    // Line sampled in the middle of the high phase
    task automatic read_bit(output logic b);
        sda_m = 1'b1;
        wait_cycles(HALF / 2);
        bus_clk = 1'b1;
        wait_cycles(HALF / 2);
        b = sda_line;
        wait_cycles(HALF / 2);
        bus_clk = 1'b0;
        wait_cycles(HALF / 2);
    endtask

    task automatic send_byte(input logic [7:0] b, output logic ack);
        logic line_bit;
        for (int i = 7; i >= 0; i--)
            send_bit(b[i]);
        read_bit(line_bit);
        ack = !line_bit;
    endtask

    // Single byte read, always closed with a NACK
    task automatic recv_byte(output logic [7:0] d);
        for (int i = 7; i >= 0; i--)
            read_bit(d[i]);
        send_bit(1'b1);
    endtask

    task automatic do_write(input logic [3:0] dev, input logic [2:0] page,
                            input logic [7:0] addr, input logic [7:0] data,
                            output logic [2:0] acks);
        send_start();
        send_byte({dev, page, 1'b0}, acks[2]);
        send_byte(addr, acks[1]);
        send_byte(data, acks[0]);
        send_stop();
        wait_cycles(HALF);
    endtask

    task automatic do_read(input logic [3:0] dev, input logic [2:0] page,
                           input logic [7:0] addr, output logic [2:0] acks,
                           output logic [7:0] rd);
        send_start();
        send_byte({dev, page, 1'b0}, acks[2]);
        send_byte(addr, acks[1]);
        send_start();
        send_byte({dev, page, 1'b1}, acks[0]);
        recv_byte(rd);
        send_stop();
        wait_cycles(HALF);
    endtask

    task automatic do_abort(input logic [3:0] dev, input logic [2:0] page,
                            input logic [7:0] addr, output logic [2:0] acks);
        send_start();
        send_byte({dev, page, 1'b0}, acks[2]);
        send_byte(addr, acks[1]);
        acks[0] = 1'b0;
        send_stop();
        wait_cycles(HALF);
    endtask

    task automatic load_stim;
        int          fd;
        logic [767:0] line;
        logic [7:0]  op;
        logic [3:0]  dev;
        logic [2:0]  page;
        logic [7:0]  addr;
        logic [7:0]  data;
        logic [2:0]  acks;
        logic [7:0]  rdata;
        fd = $fopen("testbench/eeprom_stim.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("Could not open the stimulus file testbench/eeprom_stim.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = '0;
                void'($fgets(line, fd));
                // Comment and blank lines do not yield all seven fields
                if ($sscanf(line, "%s %h %h %h %h %b %h",
                            op, dev, page, addr, data, acks, rdata) == 7)
                    stim_q.push_back({op, dev, page, addr, data, acks, rdata});
            end
            $fclose(fd);
        end
    endtask

    task automatic run_stim(input stim_t s);
        logic [2:0] acks;
        logic [7:0] rd;
        case (s.op)
            "W":
            begin
                do_write(s.dev, s.page, s.addr, s.data, acks);
                check_value(acks, s.acks, "write acknowledge flags");
                if (s.acks == 3'b111)
                    shadow[{s.page, s.addr}] = s.data;
            end
            "R":
            begin
                do_read(s.dev, s.page, s.addr, acks, rd);
                check_value(acks, s.acks, "read acknowledge flags");
                check_value(rd, s.rdata, "read data");
            end
            "A":
            begin
                do_abort(s.dev, s.page, s.addr, acks);
                check_value(acks, s.acks, "aborted write acknowledge flags");
            end
            default:
            begin
                errors++;
                $display("Unknown operation in the stimulus file, line skipped");
            end
        endcase
        check_value(sda_pull_low, 1'b0, "sda released after stop");
    endtask

    initial
    begin
        logic [2:0] acks;
        logic [7:0] rd;
        logic [7:0] val;
        logic [2:0] rnd_page [0:N_RAND-1];
        logic [7:0] rnd_addr [0:N_RAND-1];
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'h00;
        load_stim();
        cycle_limit = (stim_q.size() + 2 * N_RAND) * TXN_CYCLES + 20 * HALF;
        wait_cycles(5);
        rst = 1'b0;
        wait_cycles(HALF);
        check_value(sda_pull_low, 1'b0, "sda released after reset");

        foreach (stim_q[i])
            run_stim(stim_q[i]);

        // Random writes first, then read all back so collisions show up
        for (int i = 0; i < N_RAND; i++)
        begin
            take_bits(3, val);
            rnd_page[i] = val[2:0];
            take_bits(8, rnd_addr[i]);
            take_bits(8, val);
            do_write(DEV, rnd_page[i], rnd_addr[i], val, acks);
            check_value(acks, 3'b111, "random write acknowledge flags");
            shadow[{rnd_page[i], rnd_addr[i]}] = val;
        end
        for (int i = 0; i < N_RAND; i++)
        begin
            do_read(DEV, rnd_page[i], rnd_addr[i], acks, rd);
            check_value(acks, 3'b111, "random read acknowledge flags");
            check_value(rd, shadow[{rnd_page[i], rnd_addr[i]}], "random read data");
        end

        $display("Errors: %0d of %0d checks", errors, checks);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/eeprom_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_top #(
    parameter int         SYNC_STAGES = 2,
    parameter logic [3:0] DEVICE_CODE = 4'b1010
) (
    input  wire logic scl,
    input  wire logic rst,
    input  wire logic bus_clk,
    input  wire logic sda_in,
    output logic      sda_pull_low
);

    eeprom_pkg::bus_event_t bus_ev;
    logic                   byte_done;
    eeprom_pkg::mem_data_t  rx_byte;
    logic                   ack_done;
    logic                   master_ack;
    logic                   ack_en;
    logic                   tx_load;
    logic                   tx_mode;
    eeprom_pkg::mem_data_t  tx_byte;
    eeprom_pkg::mem_req_t   mem_req;
    eeprom_pkg::mem_data_t  rdata;

    bus_sampler #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_bus_sampler (
        .scl     (scl),
        .rst     (rst),
        .bus_clk (bus_clk),
        .sda_in  (sda_in),
        .bus_ev  (bus_ev)
    );

    byte_shifter u_byte_shifter (
        .scl          (scl),
        .rst          (rst),
        .bus_ev       (bus_ev),
        .ack_en       (ack_en),
        .tx_load      (tx_load),
        .tx_mode      (tx_mode),
        .tx_byte      (tx_byte),
        .byte_done    (byte_done),
        .rx_byte      (rx_byte),
        .ack_done     (ack_done),
        .master_ack   (master_ack),
        .sda_pull_low (sda_pull_low)
    );

    eeprom_ctrl #(
        .DEVICE_CODE (DEVICE_CODE)
    ) u_eeprom_ctrl (
        .scl        (scl),
        .rst        (rst),
        .bus_ev     (bus_ev),
        .byte_done  (byte_done),
        .rx_byte    (rx_byte),
        .ack_done   (ack_done),
        .master_ack (master_ack),
        .rdata      (rdata),
        .ack_en     (ack_en),
        .tx_load    (tx_load),
        .tx_mode    (tx_mode),
        .tx_byte    (tx_byte),
        .mem_req    (mem_req)
    );

    eeprom_array u_eeprom_array (
        .scl     (scl),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

endmodule

`default_nettype wire

// File: source/eeprom_array.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_array (
    input  wire logic                 scl,
    input  wire eeprom_pkg::mem_req_t mem_req,
    output eeprom_pkg::mem_data_t     rdata
);

    eeprom_pkg::mem_data_t mem [0:eeprom_pkg::MEM_DEPTH-1];

    // Blank device contents
    initial
    begin
        for (int i = 0; i < eeprom_pkg::MEM_DEPTH; i++)
            mem[i] = '0;
    end

    always_ff @(posedge scl)
    begin
        if (mem_req.en)
        begin
            if (mem_req.we)
                mem[mem_req.addr] <= mem_req.wdata;
            else
                rdata <= mem[mem_req.addr];
        end
    end

endmodule

`default_nettype wire

// File: source/eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl #(
    parameter logic [3:0] DEVICE_CODE = 4'b1010
) (
    input  wire logic                  scl,
    input  wire logic                  rst,
    input  wire eeprom_pkg::bus_event_t bus_ev,
    input  wire logic                  byte_done,
    input  wire eeprom_pkg::mem_data_t rx_byte,
    input  wire logic                  ack_done,
    input  wire logic                  master_ack,
    input  wire eeprom_pkg::mem_data_t rdata,
    output logic                       ack_en,
    output logic                       tx_load,
    output logic                       tx_mode,
    output eeprom_pkg::mem_data_t      tx_byte,
    output eeprom_pkg::mem_req_t       mem_req
);

    eeprom_pkg::ctrl_state_t state;
    eeprom_pkg::ctrl_byte_t  rx_ctrl;
    eeprom_pkg::page_t       page;
    eeprom_pkg::mem_data_t   addr_lo;
    logic                    ctrl_match;

    assign rx_ctrl    = eeprom_pkg::ctrl_byte_t'(rx_byte);
    assign ctrl_match = (rx_ctrl.dev_code == DEVICE_CODE);
    // Array output holds until the next read
    assign tx_byte    = rdata;

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            state      <= eeprom_pkg::IDLE;
            ack_en     <= 1'b0;
            tx_load    <= 1'b0;
            tx_mode    <= 1'b0;
            mem_req.en <= 1'b0;
            mem_req.we <= 1'b0;
        end
        else
        begin
            mem_req.en <= 1'b0;
            tx_load    <= mem_req.en && !mem_req.we;
            if (ack_done)
                ack_en <= 1'b0;
            if (bus_ev.stop)
            begin
                state   <= eeprom_pkg::IDLE;
                ack_en  <= 1'b0;
                tx_mode <= 1'b0;
            end
            else if (bus_ev.start)
            begin
                state   <= (state == eeprom_pkg::WAIT_RESTART) ?
                           eeprom_pkg::GET_RD_CTRL : eeprom_pkg::GET_CTRL;
                ack_en  <= 1'b0;
                tx_mode <= 1'b0;
            end
            else
            begin
                case (state)
                    eeprom_pkg::GET_CTRL:
                        if (byte_done)
                        begin
                            if (ctrl_match && !rx_ctrl.rd)
                                ack_en <= 1'b1;
                            else
                                state <= eeprom_pkg::IDLE;
                        end
                        else if (ack_done)
                            state <= eeprom_pkg::GET_ADDR;
                    eeprom_pkg::GET_ADDR:
                        if (byte_done)
                            ack_en <= 1'b1;
                        else if (ack_done)
                            state <= eeprom_pkg::WAIT_RESTART;
                    // A clock fall without a start means data bits are coming
                    eeprom_pkg::WAIT_RESTART:
                        if (bus_ev.clk_fall)
                            state <= eeprom_pkg::GET_DATA;
                    eeprom_pkg::GET_DATA:
                        if (byte_done)
                        begin
                            ack_en        <= 1'b1;
                            mem_req.en    <= 1'b1;
                            mem_req.we    <= 1'b1;
                            mem_req.addr  <= {page, addr_lo};
                            mem_req.wdata <= rx_byte;
                        end
                        else if (ack_done)
                            state <= eeprom_pkg::IDLE;
                    eeprom_pkg::GET_RD_CTRL:
                        if (byte_done)
                        begin
                            if (ctrl_match && rx_ctrl.rd)
                            begin
                                ack_en       <= 1'b1;
                                tx_mode      <= 1'b1;
                                mem_req.en   <= 1'b1;
                                mem_req.we   <= 1'b0;
                                mem_req.addr <= {rx_ctrl.page, addr_lo};
                                state        <= eeprom_pkg::SEND_DATA;
                            end
                            else
                                state <= eeprom_pkg::IDLE;
                        end
                    eeprom_pkg::SEND_DATA:
                        if (byte_done)
                            state <= eeprom_pkg::WAIT_MASTER_ACK;
                    eeprom_pkg::WAIT_MASTER_ACK:
                        if (ack_done)
                        begin
                            tx_mode <= 1'b0;
                            state   <= eeprom_pkg::IDLE;
                        end
                    default:
                        state <= eeprom_pkg::IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (state == eeprom_pkg::GET_CTRL && byte_done)
            page <= rx_ctrl.page;
        if (state == eeprom_pkg::GET_ADDR && byte_done)
            addr_lo <= rx_byte;
    end

    a_mem_req_single: assert property (@(posedge scl) disable iff (rst)
        mem_req.en |=> !mem_req.en)
        else $error("memory request held longer than one cycle");

    // Only one byte per read, so the master has to end with a NACK
    a_read_ends_nack: assert property (@(posedge scl) disable iff (rst)
        (state == eeprom_pkg::WAIT_MASTER_ACK && ack_done) |-> !master_ack)
        else $error("master acknowledged a single-byte read");

endmodule

`default_nettype wire

// File: source/byte_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module byte_shifter (
    input  wire logic                  scl,
    input  wire logic                  rst,
    input  wire eeprom_pkg::bus_event_t bus_ev,
    input  wire logic                  ack_en,
    input  wire logic                  tx_load,
    input  wire logic                  tx_mode,
    input  wire eeprom_pkg::mem_data_t tx_byte,
    output logic                       byte_done,
    output eeprom_pkg::mem_data_t      rx_byte,
    output logic                       ack_done,
    output logic                       master_ack,
    output logic                       sda_pull_low
);

    // Rises seen in the current frame, 8 means the ninth bit is next
    logic [3:0]            bit_cnt;
    logic [6:0]            rx_shift;
    eeprom_pkg::mem_data_t tx_shift;
    logic                  ack_slot;
    logic                  tx_pending;
    logic                  tx_active;

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            bit_cnt      <= 4'd0;
            ack_slot     <= 1'b0;
            tx_pending   <= 1'b0;
            tx_active    <= 1'b0;
            byte_done    <= 1'b0;
            ack_done     <= 1'b0;
            master_ack   <= 1'b0;
            sda_pull_low <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            ack_done  <= 1'b0;
            if (tx_load)
                tx_pending <= 1'b1;
            if (bus_ev.start || bus_ev.stop)
            begin
                bit_cnt      <= 4'd0;
                ack_slot     <= 1'b0;
                tx_pending   <= 1'b0;
                tx_active    <= 1'b0;
                sda_pull_low <= 1'b0;
            end
            else if (bus_ev.clk_rise)
            begin
                if (bit_cnt == 4'd8)
                begin
                    bit_cnt <= 4'd0;
                    // Low on the line means the master acknowledged
                    if (tx_active)
                        master_ack <= !bus_ev.sda;
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd7)
                        byte_done <= 1'b1;
                end
            end
            else if (bus_ev.clk_fall)
            begin
                if (bit_cnt == 4'd8)
                begin
                    ack_slot     <= 1'b1;
                    sda_pull_low <= tx_active ? 1'b0 : ack_en;
                end
                else if (ack_slot)
                begin
                    // End of the ninth bit, first data bit goes out here
                    ack_slot     <= 1'b0;
                    ack_done     <= 1'b1;
                    tx_active    <= tx_mode && tx_pending;
                    tx_pending   <= 1'b0;
                    sda_pull_low <= tx_mode && tx_pending && !tx_shift[7];
                end
                else if (tx_active)
                    sda_pull_low <= !tx_shift[6];
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (tx_load)
            tx_shift <= tx_byte;
        else if (bus_ev.clk_fall && tx_active && !ack_slot && bit_cnt != 4'd8)
            tx_shift <= tx_shift << 1;
        if (bus_ev.clk_rise && bit_cnt < 4'd8)
            rx_shift <= {rx_shift[5:0], bus_ev.sda};
        if (bus_ev.clk_rise && bit_cnt == 4'd7)
            rx_byte <= {rx_shift, bus_ev.sda};
    end

    a_pull_low_on_fall: assert property (@(posedge scl) disable iff (rst)
        $changed(sda_pull_low) |-> $past(bus_ev.clk_fall || bus_ev.stop))
        else $error("sda_pull_low changed outside a bus clock fall or stop");

endmodule

`default_nettype wire

// File: source/bus_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module bus_sampler #(
    parameter int SYNC_STAGES = 2
) (
    input  wire logic             scl,
    input  wire logic             rst,
    input  wire logic             bus_clk,
    input  wire logic             sda_in,
    output eeprom_pkg::bus_event_t bus_ev
);

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] sda_sync;
    logic                   clk_prev;
    logic                   sda_prev;
    logic                   clk_s;
    logic                   sda_s;

    assign clk_s = clk_sync[SYNC_STAGES-1];
    assign sda_s = sda_sync[SYNC_STAGES-1];

    // Idle bus is high on both lines
    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            clk_sync <= '1;
            sda_sync <= '1;
            clk_prev <= 1'b1;
            sda_prev <= 1'b1;
            bus_ev   <= '{start: 1'b0, stop: 1'b0, clk_rise: 1'b0, clk_fall: 1'b0, sda: 1'b1};
        end
        else
        begin
            clk_sync <= {clk_sync[SYNC_STAGES-2:0], bus_clk};
            sda_sync <= {sda_sync[SYNC_STAGES-2:0], sda_in};
            clk_prev <= clk_s;
            sda_prev <= sda_s;
            bus_ev.clk_rise <= clk_s && !clk_prev;
            bus_ev.clk_fall <= !clk_s && clk_prev;
            // sda may only move with the clock high for start and stop
            bus_ev.start    <= clk_s && clk_prev && sda_prev && !sda_s;
            bus_ev.stop     <= clk_s && clk_prev && !sda_prev && sda_s;
            bus_ev.sda      <= sda_s;
        end
    end

endmodule

`default_nettype wire

// File: source/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;
    localparam int MEM_DEPTH = 2 ** ADDR_W;

    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [DATA_W-1:0] mem_data_t;

    // Upper address bits carried in the control byte
    typedef logic [ADDR_W-DATA_W-1:0] page_t;

    typedef struct packed {
        logic [3:0] dev_code;
        page_t      page;
        logic       rd;
    } ctrl_byte_t;

    // Strobes are one system cycle wide, sda is a level
    typedef struct packed {
        logic start;
        logic stop;
        logic clk_rise;
        logic clk_fall;
        logic sda;
    } bus_event_t;

    typedef struct packed {
        logic      en;
        logic      we;
        mem_addr_t addr;
        mem_data_t wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        GET_CTRL,
        GET_ADDR,
        GET_DATA,
        WAIT_RESTART,
        GET_RD_CTRL,
        SEND_DATA,
        WAIT_MASTER_ACK
    } ctrl_state_t;

endpackage

`default_nettype wire
